// ==== vlog.f ====
common/core_pkg.sv
common/isa_pkg.sv
rtl/control_unit.sv
rtl/fetch_unit.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/data_mem.sv
rtl/cpu_top.sv
dv/tb_clock.sv
dv/cpu_asserts.sv
dv/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the core and its testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module cpu_tb -f vlog.f -o cpu_sim; then
        echo "verilator build failed"
        exit 1
fi

if ! out=$(./obj_dir/cpu_sim +verilator+error+limit+1000); then
        echo "$out"
        echo "simulation exited with an error status"
        exit 1
fi
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="; then
        exit 0
fi
exit 1

// ==== dv/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb
        import core_pkg::*;
        import isa_pkg::*;
();

        logic       clk;
        logic       rst_n;
        logic       run;
        logic       imem_we;
        pc_t        imem_addr;
        instr_t     imem_wdata;
        pc_t        pc;
        logic       wb_en;
        reg_idx_t   wb_idx;
        word_t      wb_data;
        logic       store_en;
        dmem_addr_t store_addr;
        word_t      store_data;

        instr_t      progs [5][$];
        string       names [5] = '{"reg-reg alu", "immediate", "memory", "branch", "jump"};
        opcode_t     rr_ops [7] = '{OPC_ADD, OPC_SUB, OPC_NOT, OPC_AND, OPC_OR, OPC_NAND, OPC_NOR};
        opcode_t     imm_ops [4] = '{OPC_ADDI, OPC_SUBI, OPC_LI, OPC_MOV};
        instr_t      imem_m [IMEM_DEPTH];              // copy of what was loaded
        word_t       m_regs [REG_COUNT];
        word_t       m_mem [DMEM_DEPTH];
        pc_t         m_pc;
        logic [31:0] rng;
        int          errors;
        int          tests_failed;
        int          run_cycles;
        int          limit;

        tb_clock i_tb_clock (
                .clk   (clk),
                .rst_n (rst_n)
        );

        cpu_top i_cpu_top (
                .clk        (clk),
                .rst_n      (rst_n),
                .run        (run),
                .imem_we    (imem_we),
                .imem_addr  (imem_addr),
                .imem_wdata (imem_wdata),
                .pc         (pc),
                .wb_en      (wb_en),
                .wb_idx     (wb_idx),
                .wb_data    (wb_data),
                .store_en   (store_en),
                .store_addr (store_addr),
                .store_data (store_data)
        );

        bind cpu_top cpu_asserts i_cpu_asserts (
                .clk      (clk),
                .rst_n    (rst_n),
                .run      (run),
                .pc       (pc),
                .wb_en    (wb_en),
                .store_en (store_en),
                .beq      (beq),
                .bne      (bne),
                .jump     (jump)
        );

        function automatic logic [31:0] xorshift(input logic [31:0] s);
                logic [31:0] x;
                x = s ^ (s << 13);
                x = x ^ (x >> 17);
                x = x ^ (x << 5);
                return x;
        endfunction

        function automatic logic [3:0] rand4();
                rng = xorshift(rng);
                return rng[3:0];
        endfunction

        function automatic int pick(input int n);
                rng = xorshift(rng);
                return int'(rng[15:0]) % n;
        endfunction

        function automatic instr_t encode(input opcode_t op, input logic [3:0] f2,
                                          input logic [3:0] f1, input logic [3:0] f0);
                return {op, f2, f1, f0};
        endfunction

        function automatic int total_errors();
                return errors + int'(i_cpu_top.i_cpu_asserts.fail_cnt);
        endfunction

        task automatic check_value(input string name, input word_t exp, input word_t act);
                assert (act === exp) else begin
                        $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
                        errors++;
                end
        endtask

        task automatic build_programs();
                logic [3:0] ra;
                logic [3:0] v;
                for (int k = 1; k <= 8; k++) begin
                        progs[0].push_back(encode(OPC_LI, 4'd0, 4'(k), rand4()));   // seed r1..r8
                end
                for (int k = 0; k < 14; k++) begin
                        progs[0].push_back(encode(rr_ops[pick(7)], rand4(), rand4(), rand4()));
                end
                for (int k = 0; k < 12; k++) begin
                        progs[1].push_back(encode(imm_ops[pick(4)], rand4(), rand4(), rand4()));
                end
                for (int k = 0; k < 4; k++) begin
                        ra = 4'(1 + pick(5));
                        v  = rand4();                  // offset shared by sw and lw
                        progs[2].push_back(encode(OPC_LI, 4'd0, ra, rand4()));
                        progs[2].push_back(encode(OPC_LI, 4'd0, ra + 4'd5, rand4()));
                        progs[2].push_back(encode(OPC_SW, ra, ra + 4'd5, v));
                        progs[2].push_back(encode(OPC_LW, ra, ra + 4'd10, v));
                end
                v = rand4();
                progs[3].push_back(encode(OPC_LI, 4'd0, 4'd1, v));
                progs[3].push_back(encode(OPC_LI, 4'd0, 4'd2, v));
                progs[3].push_back(encode(OPC_BEQ, 4'd1, 4'd2, 4'd1));     // taken
                progs[3].push_back(encode(OPC_LI, 4'd0, 4'd3, rand4()));
                progs[3].push_back(encode(OPC_BNE, 4'd1, 4'd2, 4'd1));     // not taken
                progs[3].push_back(encode(OPC_LI, 4'd0, 4'd4, rand4()));
                progs[3].push_back(encode(OPC_LI, 4'd0, 4'd2, v ^ 4'd1));
                progs[3].push_back(encode(OPC_BEQ, 4'd1, 4'd2, 4'd2));     // not taken
                progs[3].push_back(encode(OPC_LI, 4'd0, 4'd5, rand4()));
                progs[3].push_back(encode(OPC_BNE, 4'd1, 4'd2, 4'd2));     // taken, skips two
                progs[3].push_back(encode(OPC_LI, 4'd0, 4'd6, rand4()));
                progs[3].push_back(encode(OPC_LI, 4'd0, 4'd7, rand4()));
                progs[3].push_back(encode(OPC_LI, 4'd0, 4'd8, rand4()));
                progs[4].push_back(encode(OPC_JUMP, rand4(), 4'd0, 4'd3));  // noise in upper bits
                progs[4].push_back(encode(OPC_LI, 4'd0, 4'd1, rand4()));
                progs[4].push_back(encode(OPC_LI, 4'd0, 4'd2, rand4()));
                progs[4].push_back(encode(OPC_LI, 4'd0, 4'd3, rand4()));
                progs[4].push_back(encode(OPC_JUMP, rand4(), 4'd0, 4'd6));
                progs[4].push_back(encode(OPC_LI, 4'd0, 4'd4, rand4()));
                progs[4].push_back(encode(OPC_LI, 4'd0, 4'd5, rand4()));
        endtask

        // reference model, one instruction per falling edge while running
        task automatic step_model();
                instr_t   ins;
                opcode_t  op;
                word_t    a;
                word_t    b;
                word_t    imm;
                word_t    ea;
                word_t    res;
                reg_idx_t widx;
                logic     exp_wb;
                logic     exp_st;
                pc_t      nxt;
                ins    = imem_m[m_pc];
                op     = ins[15:12];
                a      = m_regs[ins[11:8]];
                b      = m_regs[ins[7:4]];
                imm    = {{12{ins[3]}}, ins[3:0]};
                ea     = a + imm;
                res    = '0;
                nxt    = m_pc + 8'd1;
                widx   = (op inside {OPC_ADDI, OPC_SUBI, OPC_MOV, OPC_LI, OPC_LW}) ? ins[7:4] : ins[3:0];
                exp_wb = !(op inside {OPC_SW, OPC_BEQ, OPC_BNE, OPC_JUMP});
                exp_st = (op == OPC_SW);
                case (op)
                        OPC_ADD:  res = a + b;
                        OPC_ADDI: res = a + imm;
                        OPC_SUB:  res = a - b;
                        OPC_SUBI: res = a - imm;
                        OPC_NOT:  res = ~a;
                        OPC_AND:  res = a & b;
                        OPC_OR:   res = a | b;
                        OPC_NAND: res = ~(a & b);
                        OPC_NOR:  res = ~(a | b);
                        OPC_MOV:  res = a;
                        OPC_LI:   res = imm;
                        OPC_LW:   res = m_mem[ea[7:0]];
                        OPC_BEQ:  nxt = (a == b) ? m_pc + 8'd1 + imm[7:0] : nxt;
                        OPC_BNE:  nxt = (a != b) ? m_pc + 8'd1 + imm[7:0] : nxt;
                        OPC_JUMP: nxt = ins[7:0];
                        default:  res = '0;            // sw
                endcase
                check_value("pc", 16'(m_pc), 16'(pc));
                check_value("wb_en", 16'(exp_wb), 16'(wb_en));
                check_value("store_en", 16'(exp_st), 16'(store_en));
                if (exp_wb) begin
                        check_value("wb_idx", 16'(widx), 16'(wb_idx));
                        check_value("wb_data", res, wb_data);
                        m_regs[widx] = res;
                end
                if (exp_st) begin
                        check_value("store_addr", 16'(ea[7:0]), 16'(store_addr));
                        check_value("store_data", b, store_data);
                        m_mem[ea[7:0]] = b;
                end
                m_pc = nxt;
        endtask

        task automatic report_test(input string name, input int base);
                int n;
                n = total_errors() - base;
                if (n != 0) begin
                        tests_failed++;
                end
                $display("test %-12s %s, %0d mismatches", name, (n == 0) ? "ok" : "failed", n);
        endtask

        task automatic run_program(input int t);
                int base;
                base = total_errors();
                for (int i = 0; i < progs[t].size(); i++) begin
                        imem_we    = 1'b1;
                        imem_addr  = pc_t'(i);
                        imem_wdata = progs[t][i];
                        imem_m[i]  = progs[t][i];
                        @(posedge clk);
                        #1;
                end
                imem_we = 1'b0;
                m_pc    = '0;
                run     = 1'b1;
                do begin
                        @(posedge clk);
                        #1;
                end while (pc != pc_t'(progs[t].size()));
                run = 1'b0;
                @(posedge clk);
                #1;
                report_test(names[t], base);
        endtask

        always @(negedge clk) begin
                if (run) begin
                        step_model();
                end
        end

        always @(posedge clk) begin
                if (run) begin
                        run_cycles++;
                        if (run_cycles > limit) begin
                                $display("timeout: a program did not reach its end within %0d cycles",
                                         limit);
                                $display("=== FAIL ===");
                                $finish;
                        end
                end
        end

        initial begin
                int base;
                run          = 1'b0;
                imem_we      = 1'b0;
                imem_addr    = '0;
                imem_wdata   = '0;
                rng          = 32'h1ade_9ab0;
                errors       = 0;
                tests_failed = 0;
                run_cycles   = 0;
                for (int i = 0; i < REG_COUNT; i++) begin
                        m_regs[i] = '0;                // matches the register reset
                end
                build_programs();
                limit = 64;
                for (int t = 0; t < 5; t++) begin
                        limit += progs[t].size();
                end
                wait (rst_n === 1'b1);
                @(posedge clk);
                #1;
                base = total_errors();
                check_value("pc", 16'd0, 16'(pc));
                check_value("wb_en", 16'd0, 16'(wb_en));
                check_value("store_en", 16'd0, 16'(store_en));
                report_test("reset", base);
                for (int t = 0; t < 5; t++) begin
                        run_program(t);
                end
                $display("6 tests, %0d failed, %0d value errors, %0d assertion failures",
                         tests_failed, errors, i_cpu_top.i_cpu_asserts.fail_cnt);
                if (total_errors() == 0) begin
                        $display("=== PASS ===");
                end else begin
                        $display("=== FAIL ===");
                end
                $finish;
        end

endmodule

// ==== dv/cpu_asserts.sv ====
`timescale 1ns/1ps

module cpu_asserts
        import core_pkg::*;
(
        input logic clk,
        input logic rst_n,
        input logic run,
        input pc_t  pc,
        input logic wb_en,
        input logic store_en,
        input logic beq,
        input logic bne,
        input logic jump
);

        int unsigned fail_cnt = 0;                     // failed assertion count

        halted_quiet: assert property (@(posedge clk) disable iff (!rst_n)
                        !run |-> (!wb_en && !store_en))
                else begin
                        fail_cnt++;
                        $error("register or memory write enabled while run is low");
                end

        one_effect: assert property (@(posedge clk) disable iff (!rst_n)
                        !(wb_en && store_en))
                else begin
                        fail_cnt++;
                        $error("wb_en and store_en high in the same cycle");
                end

        pc_step: assert property (@(posedge clk) disable iff (!rst_n)
                        (run && !beq && !bne && !jump) |=> (pc == $past(pc) + 8'd1))
                else begin
                        fail_cnt++;
                        $error("pc did not advance by one after a plain instruction");
                end

        reset_quiet: assert property (@(posedge clk)
                        $rose(rst_n) |-> (!wb_en && !store_en))
                else begin
                        fail_cnt++;
                        $error("write enable high in the first cycle after reset");
                end

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
        output logic clk,
        output logic rst_n
);

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;                // 20 ns period
        end

        initial begin
                rst_n = 1'b0;
                repeat (8) @(posedge clk);
                #1 rst_n = 1'b1;                       // release just after an edge
        end

endmodule

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top
        import core_pkg::*;
        import isa_pkg::*;
(
        input  logic       clk,
        input  logic       rst_n,
        input  logic       run,
        input  logic       imem_we,
        input  pc_t        imem_addr,
        input  instr_t     imem_wdata,
        output pc_t        pc,
        output logic       wb_en,
        output reg_idx_t   wb_idx,
        output word_t      wb_data,
        output logic       store_en,
        output dmem_addr_t store_addr,
        output word_t      store_data
);

        instr_t   instr;
        opcode_t  opcode;
        reg_idx_t rs_idx;
        reg_idx_t rt_idx;
        reg_idx_t rd_idx;
        word_t    imm_ext;
        word_t    rs_data;
        word_t    rt_data;
        word_t    alu_b;
        word_t    alu_result;
        word_t    mem_rdata;
        logic     reg_dst;
        logic     alu_src;
        logic     mem_to_reg;
        logic     reg_write;
        logic     beq;
        logic     bne;
        logic     jump;
        alu_op_t  alu_op;
        mem_op_t  mem_op;

        assign opcode  = instr[OPC_LSB +: 4];
        assign rs_idx  = instr[RS_LSB +: REG_IDX_W];
        assign rt_idx  = instr[RT_LSB +: REG_IDX_W];
        assign rd_idx  = instr[RD_LSB +: REG_IDX_W];
        assign imm_ext = {{(WORD_W-IMM_W){instr[IMM_LSB+IMM_W-1]}}, instr[IMM_LSB +: IMM_W]};
        assign alu_b   = alu_src ? imm_ext : rt_data;

        // effects of the current instruction, committed at the next edge
        assign wb_en      = reg_write && run;
        assign wb_idx     = reg_dst ? rd_idx : rt_idx;
        assign wb_data    = mem_to_reg ? mem_rdata : alu_result;
        assign store_en   = (mem_op == MEM_OP_WRITE) && run;
        assign store_addr = alu_result[DMEM_ADDR_W-1:0];     // rs + imm
        assign store_data = rt_data;

        fetch_unit i_fetch_unit (
                .clk        (clk),
                .rst_n      (rst_n),
                .run        (run),
                .imem_we    (imem_we),
                .imem_addr  (imem_addr),
                .imem_wdata (imem_wdata),
                .beq        (beq),
                .bne        (bne),
                .jump       (jump),
                .rs_data    (rs_data),
                .rt_data    (rt_data),
                .pc         (pc),
                .instr      (instr)
        );

        control_unit i_control_unit (
                .opcode     (opcode),
                .reg_dst    (reg_dst),
                .alu_src    (alu_src),
                .mem_to_reg (mem_to_reg),
                .reg_write  (reg_write),
                .beq        (beq),
                .bne        (bne),
                .jump       (jump),
                .alu_op     (alu_op),
                .mem_op     (mem_op)
        );

        reg_file i_reg_file (
                .clk   (clk),
                .rst_n (rst_n),
                .we    (wb_en),
                .ra    (rs_idx),
                .rb    (rt_idx),
                .wa    (wb_idx),
                .wd    (wb_data),
                .rda   (rs_data),
                .rdb   (rt_data)
        );

        alu i_alu (
                .alu_op (alu_op),
                .a      (rs_data),
                .b      (alu_b),
                .result (alu_result)
        );

        data_mem i_data_mem (
                .clk  (clk),
                .we   (store_en),
                .addr (store_addr),
                .wd   (store_data),
                .rd   (mem_rdata)
        );

endmodule

// ==== rtl/data_mem.sv ====
`timescale 1ns/1ps

module data_mem
        import core_pkg::*;
(
        input  logic       clk,
        input  logic       we,
        input  dmem_addr_t addr,
        input  word_t      wd,
        output word_t      rd
);

        word_t mem [DMEM_DEPTH];

        assign rd = mem[addr];                      // read is combinational

        always_ff @(posedge clk) begin
                if (we) begin
                        mem[addr] <= wd;
                end
        end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu
        import core_pkg::*;
        import isa_pkg::*;
(
        input  alu_op_t alu_op,
        input  word_t   a,
        input  word_t   b,
        output word_t   result
);

        always_comb begin
                case (alu_op)
                        ALU_OP_ADD:  result = a + b;       // wraps at 16 bits
                        ALU_OP_SUB:  result = a - b;
                        ALU_OP_NOT:  result = ~a;
                        ALU_OP_AND:  result = a & b;
                        ALU_OP_OR:   result = a | b;
                        ALU_OP_NAND: result = ~(a & b);
                        ALU_OP_NOR:  result = ~(a | b);
                        ALU_OP_MOV:  result = a;
                        ALU_OP_LI:   result = b;           // immediate via operand b
                        default:     result = '0;
                endcase
        end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
        import core_pkg::*;
(
        input  logic     clk,
        input  logic     rst_n,
        input  logic     we,
        input  reg_idx_t ra,
        input  reg_idx_t rb,
        input  reg_idx_t wa,
        input  word_t    wd,
        output word_t    rda,
        output word_t    rdb
);

        word_t regs [REG_COUNT];

        assign rda = regs[ra];
        assign rdb = regs[rb];

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < REG_COUNT; i++) begin
                                regs[i] <= '0;
                        end
                end else if (we) begin
                        regs[wa] <= wd;                // r0 is a normal register
                end
        end

endmodule

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit
        import core_pkg::*;
        import isa_pkg::*;
(
        input  logic   clk,
        input  logic   rst_n,
        input  logic   run,
        input  logic   imem_we,
        input  pc_t    imem_addr,
        input  instr_t imem_wdata,
        input  logic   beq,
        input  logic   bne,
        input  logic   jump,
        input  word_t  rs_data,
        input  word_t  rt_data,
        output pc_t    pc,
        output instr_t instr
);

        instr_t              imem [IMEM_DEPTH];
        logic [TARGET_W-1:0] target;
        pc_t                 br_off;
        pc_t                 pc_inc;
        pc_t                 pc_next;
        logic                take_br;

        assign instr   = imem[pc];                  // async fetch
        assign target  = instr[TARGET_LSB +: TARGET_W];
        assign br_off  = {{(PC_W-IMM_W){instr[IMM_LSB+IMM_W-1]}}, instr[IMM_LSB +: IMM_W]};
        assign pc_inc  = pc + 1'b1;
        assign take_br = (beq && (rs_data == rt_data)) || (bne && (rs_data != rt_data));

        always_comb begin
                if (jump) begin
                        pc_next = target[PC_W-1:0];    // upper target bits ignored
                end else if (take_br) begin
                        pc_next = pc_inc + br_off;
                end else begin
                        pc_next = pc_inc;
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        pc <= '0;
                end else if (!run) begin
                        pc <= '0;                      // parked at 0 while loading
                end else begin
                        pc <= pc_next;
                end
        end

        always_ff @(posedge clk) begin
                if (!run && imem_we) begin
                        imem[imem_addr] <= imem_wdata;
                end
        end

endmodule

// ==== rtl/control_unit.sv ====
`timescale 1ns/1ps

module control_unit
        import isa_pkg::*;
(
        input  opcode_t opcode,
        output logic    reg_dst,
        output logic    alu_src,
        output logic    mem_to_reg,
        output logic    reg_write,
        output logic    beq,
        output logic    bne,
        output logic    jump,
        output alu_op_t alu_op,
        output mem_op_t mem_op
);

        always_comb begin
                reg_dst    = 1'b0;                 // rt is the default destination
                alu_src    = 1'b0;
                mem_to_reg = 1'b0;
                reg_write  = 1'b0;
                beq        = 1'b0;
                bne        = 1'b0;
                jump       = 1'b0;
                alu_op     = ALU_OP_ADD;
                mem_op     = MEM_OP_NOP;

                case (opcode)
                        OPC_ADD: begin
                                reg_dst   = 1'b1;
                                reg_write = 1'b1;
                        end
                        OPC_ADDI: begin
                                alu_src   = 1'b1;
                                reg_write = 1'b1;
                        end
                        OPC_SUB: begin
                                reg_dst   = 1'b1;
                                reg_write = 1'b1;
                                alu_op    = ALU_OP_SUB;
                        end
                        OPC_SUBI: begin
                                alu_src   = 1'b1;
                                reg_write = 1'b1;
                                alu_op    = ALU_OP_SUB;
                        end
                        OPC_NOT: begin
                                reg_dst   = 1'b1;
                                reg_write = 1'b1;
                                alu_op    = ALU_OP_NOT;
                        end
                        OPC_AND: begin
                                reg_dst   = 1'b1;
                                reg_write = 1'b1;
                                alu_op    = ALU_OP_AND;
                        end
                        OPC_OR: begin
                                reg_dst   = 1'b1;
                                reg_write = 1'b1;
                                alu_op    = ALU_OP_OR;
                        end
                        OPC_NAND: begin
                                reg_dst   = 1'b1;
                                reg_write = 1'b1;
                                alu_op    = ALU_OP_NAND;
                        end
                        OPC_NOR: begin
                                reg_dst   = 1'b1;
                                reg_write = 1'b1;
                                alu_op    = ALU_OP_NOR;
                        end
                        OPC_MOV: begin
                                reg_write = 1'b1;
                                alu_op    = ALU_OP_MOV;
                        end
                        OPC_LI: begin
                                alu_src   = 1'b1;
                                reg_write = 1'b1;
                                alu_op    = ALU_OP_LI;
                        end
                        OPC_LW: begin
                                alu_src    = 1'b1;         // rs + imm address
                                mem_to_reg = 1'b1;
                                reg_write  = 1'b1;
                                mem_op     = MEM_OP_READ;
                        end
                        OPC_SW: begin
                                alu_src = 1'b1;
                                mem_op  = MEM_OP_WRITE;
                        end
                        OPC_BEQ:  beq  = 1'b1;             // condition tested in fetch
                        OPC_BNE:  bne  = 1'b1;
                        OPC_JUMP: jump = 1'b1;
                endcase
        end

endmodule

// ==== common/isa_pkg.sv ====
package isa_pkg;

        typedef logic [15:0] instr_t;
        typedef logic [3:0]  opcode_t;
        typedef logic [3:0]  alu_op_t;
        typedef logic [1:0]  mem_op_t;

        // field positions inside instr_t
        localparam int OPC_LSB    = 12;
        localparam int RS_LSB     = 8;
        localparam int RT_LSB     = 4;
        localparam int RD_LSB     = 0;
        localparam int IMM_LSB    = 0;
        localparam int IMM_W      = 4;             // sign-extended where used
        localparam int TARGET_LSB = 0;
        localparam int TARGET_W   = 12;            // jump only, low bits reach the pc

        localparam opcode_t OPC_ADD  = 4'd0;
        localparam opcode_t OPC_ADDI = 4'd1;
        localparam opcode_t OPC_SUB  = 4'd2;
        localparam opcode_t OPC_SUBI = 4'd3;
        localparam opcode_t OPC_NOT  = 4'd4;
        localparam opcode_t OPC_AND  = 4'd5;
        localparam opcode_t OPC_OR   = 4'd6;
        localparam opcode_t OPC_NAND = 4'd7;
        localparam opcode_t OPC_NOR  = 4'd8;
        localparam opcode_t OPC_MOV  = 4'd9;
        localparam opcode_t OPC_LI   = 4'd10;
        localparam opcode_t OPC_LW   = 4'd11;
        localparam opcode_t OPC_SW   = 4'd12;
        localparam opcode_t OPC_BEQ  = 4'd13;
        localparam opcode_t OPC_BNE  = 4'd14;
        localparam opcode_t OPC_JUMP = 4'd15;

        localparam alu_op_t ALU_OP_ADD  = 4'd0;
        localparam alu_op_t ALU_OP_SUB  = 4'd1;
        localparam alu_op_t ALU_OP_NOT  = 4'd2;
        localparam alu_op_t ALU_OP_AND  = 4'd3;
        localparam alu_op_t ALU_OP_OR   = 4'd4;
        localparam alu_op_t ALU_OP_NAND = 4'd5;
        localparam alu_op_t ALU_OP_NOR  = 4'd6;
        localparam alu_op_t ALU_OP_MOV  = 4'd7;
        localparam alu_op_t ALU_OP_LI   = 4'd8;

        localparam mem_op_t MEM_OP_NOP   = 2'd0;
        localparam mem_op_t MEM_OP_READ  = 2'd1;
        localparam mem_op_t MEM_OP_WRITE = 2'd2;

endpackage

// ==== common/core_pkg.sv ====
package core_pkg;

        localparam int WORD_W      = 16;
        localparam int REG_IDX_W   = 4;
        localparam int PC_W        = 8;
        localparam int DMEM_ADDR_W = 8;

        localparam int IMEM_DEPTH  = 256;          // one instruction per pc value
        localparam int DMEM_DEPTH  = 256;
        localparam int REG_COUNT   = 16;

        typedef logic [WORD_W-1:0]      word_t;
        typedef logic [REG_IDX_W-1:0]   reg_idx_t;
        typedef logic [PC_W-1:0]        pc_t;
        typedef logic [DMEM_ADDR_W-1:0] dmem_addr_t;

endpackage
